// ==== common/mem_pkg.sv ====
/*
 * Memory port types for the blimp core. Request and response messages
 * shared by the instruction and data ports, with an opaque tag.
 */
package mem_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------

  // Opaque tag echoed back by the memory
  localparam int MEM_TAG_BITS  = 8;
  localparam int MEM_ADDR_BITS = 32;
  localparam int MEM_DATA_BITS = 32;

  // ------------------------------------------------------------
  // Messages
  // ------------------------------------------------------------

  typedef enum logic [0:0] {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                  op;
    logic [MEM_TAG_BITS-1:0]  tag;
    logic [MEM_ADDR_BITS-1:0] addr;
    logic [MEM_DATA_BITS-1:0] data;
  } mem_req_t;

  // Write responses carry no useful data
  typedef struct packed {
    mem_op_e                  op;
    logic [MEM_TAG_BITS-1:0]  tag;
    logic [MEM_DATA_BITS-1:0] data;
  } mem_resp_t;

endpackage

// ==== common/core_pkg.sv ====
/*
 * Core types for the blimp core. Instruction opcodes, the decoded
 * instruction, the retire trace record and the boot address.
 */
package core_pkg;

  // First fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0000_0200;

  localparam int NUM_REGS      = 32;
  localparam int REG_ADDR_BITS = 5;

  // ------------------------------------------------------------
  // RV32I major opcodes
  // ------------------------------------------------------------

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Anything outside the supported set decodes to op_nop
  typedef enum logic [3:0] {
    op_addi,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_lui,
    op_lw,
    op_sw,
    op_bne,
    op_nop
  } inst_op_e;

  typedef struct packed {
    inst_op_e                 op;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [31:0]              imm;
    logic [31:0]              pc;
  } decoded_inst_t;

  // One record per retired instruction
  typedef struct packed {
    logic [31:0]              pc;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic [31:0]              wdata;
    logic                     wen;
  } trace_t;

endpackage

// ==== core/fetch_unit.sv ====
/*
 * Instruction fetch. Holds the PC, sends one fetch at a time on the
 * instruction port and passes each word on to execute.
 */
module fetch_unit
  import mem_pkg::*, core_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  output logic        imem_req_val,
  output mem_req_t    imem_req,
  input  logic        imem_req_rdy,
  input  logic        imem_resp_val,
  input  mem_resp_t   imem_resp,
  output logic        imem_resp_rdy,
  output logic        inst_val,
  output logic [31:0] inst_word,
  output logic [31:0] inst_pc,
  input  logic        redirect_val,
  input  logic [31:0] next_pc
);

  typedef enum logic [1:0] {
    fetch_req,
    fetch_wait,
    fetch_hold
  } fetch_state_e;

  fetch_state_e            state_q;
  logic [31:0]             pc_q;
  logic [MEM_TAG_BITS-1:0] tag_q;
  logic                    req_val_q;
  logic                    inst_val_q;
  logic [31:0]             inst_word_q;

  // ------------------------------------------------------------
  // Fetch FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= fetch_req;
      pc_q       <= RESET_PC;
      tag_q      <= '0;
      req_val_q  <= 1'b0;
      inst_val_q <= 1'b0;
    end else begin
      inst_val_q <= 1'b0;
      case (state_q)
        fetch_req: begin
          // Request only goes out once reset has been released
          if (!req_val_q) begin
            req_val_q <= 1'b1;
          end else if (imem_req_rdy) begin
            req_val_q <= 1'b0;
            state_q   <= fetch_wait;
          end
        end
        fetch_wait: begin
          if (imem_resp_val) begin
            inst_val_q <= 1'b1;
            tag_q      <= tag_q + 1'b1;
            state_q    <= fetch_hold;
          end
        end
        fetch_hold: begin
          // Idle until execute retires the word
          if (redirect_val) begin
            pc_q      <= next_pc;
            req_val_q <= 1'b1;
            state_q   <= fetch_req;
          end
        end
        default: state_q <= fetch_req;
      endcase
    end
  end

  // Fetched word
  always_ff @(posedge clk) begin
    if (state_q == fetch_wait && imem_resp_val) begin
      inst_word_q <= imem_resp.data;
    end
  end

  assign imem_req_val  = req_val_q;
  assign imem_req      = '{op: mem_read, tag: tag_q, addr: pc_q, data: '0};
  assign imem_resp_rdy = (state_q == fetch_wait);

  assign inst_val  = inst_val_q;
  assign inst_word = inst_word_q;
  assign inst_pc   = pc_q;

  // Memory must echo the tag of the single fetch in flight
  a_imem_tag_match: assert property (@(posedge clk) disable iff (reset)
    imem_resp_val && imem_resp_rdy |-> imem_resp.tag == tag_q);

endmodule

// ==== core/execute_unit.sv ====
/*
 * Execute stage. Decodes the fetched word, reads and writes the register
 * file, runs the ALU, resolves BNE and redirects fetch on retire.
 */
module execute_unit
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        inst_val,
  input  logic [31:0] inst_word,
  input  logic [31:0] inst_pc,
  output logic        redirect_val,
  output logic [31:0] next_pc,
  output logic        mem_val,
  output logic        mem_is_store,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic        retire_val,
  output trace_t      retire,
  input  logic        load_val,
  input  logic [31:0] load_data
);

  typedef enum logic [1:0] {
    ex_idle,
    ex_exec,
    ex_mem
  } ex_state_e;

  ex_state_e     state_q;
  decoded_inst_t d_q;
  logic          redirect_val_q;
  logic [31:0]   next_pc_q;

  logic [31:0] rf [NUM_REGS];
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] alu_result;
  logic [31:0] next_pc_d;
  logic        is_mem;
  logic        writes_rd;
  logic        rf_wen;
  logic [REG_ADDR_BITS-1:0] rf_waddr;
  logic [31:0] rf_wdata;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------

  function automatic decoded_inst_t decode(input logic [31:0] w, input logic [31:0] pc);
    decoded_inst_t d;
    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    opcode = w[6:0];
    funct3 = w[14:12];
    funct7 = w[31:25];
    d.op   = op_nop;
    d.rd   = w[11:7];
    d.rs1  = w[19:15];
    d.rs2  = w[24:20];
    d.pc   = pc;
    // I-type immediate unless the format says otherwise
    d.imm  = {{20{w[31]}}, w[31:20]};
    case (opcode)
      OPC_OP_IMM: if (funct3 == 3'b000) d.op = op_addi;
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: d.op = op_add;
          10'b0100000_000: d.op = op_sub;
          10'b0000000_111: d.op = op_and;
          10'b0000000_110: d.op = op_or;
          default:         d.op = op_nop;
        endcase
      end
      OPC_LUI: begin
        d.op  = op_lui;
        d.imm = {w[31:12], 12'b0};
      end
      OPC_LOAD: if (funct3 == 3'b010) d.op = op_lw;
      OPC_STORE: begin
        if (funct3 == 3'b010) d.op = op_sw;
        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b001) d.op = op_bne;
        d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      default: d.op = op_nop;
    endcase
    // No destination register for these
    if (d.op inside {op_sw, op_bne, op_nop}) d.rd = '0;
    return d;
  endfunction

  // ------------------------------------------------------------
  // Register read and ALU
  // ------------------------------------------------------------

  // x0 reads as zero
  assign rs1_val = (d_q.rs1 == '0) ? 32'd0 : rf[d_q.rs1];
  assign rs2_val = (d_q.rs2 == '0) ? 32'd0 : rf[d_q.rs2];

  always_comb begin
    case (d_q.op)
      op_add:       alu_result = rs1_val + rs2_val;
      op_sub:       alu_result = rs1_val - rs2_val;
      op_and:       alu_result = rs1_val & rs2_val;
      op_or:        alu_result = rs1_val | rs2_val;
      op_lui:       alu_result = d_q.imm;
      // ADDI, and the address for LW and SW
      default:      alu_result = rs1_val + d_q.imm;
    endcase
  end

  assign is_mem    = (d_q.op == op_lw) || (d_q.op == op_sw);
  assign writes_rd = d_q.op inside {op_addi, op_add, op_sub, op_and, op_or, op_lui};

  // Taken BNE jumps, everything else falls through
  assign next_pc_d = (d_q.op == op_bne && rs1_val != rs2_val) ? d_q.pc + d_q.imm
                                                              : d_q.pc + 32'd4;

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q        <= ex_idle;
      redirect_val_q <= 1'b0;
    end else begin
      redirect_val_q <= 1'b0;
      case (state_q)
        ex_idle: if (inst_val) state_q <= ex_exec;
        ex_exec: begin
          if (is_mem) begin
            state_q <= ex_mem;
          end else begin
            redirect_val_q <= 1'b1;
            state_q        <= ex_idle;
          end
        end
        // Held until the data port answers
        ex_mem: begin
          if (load_val) begin
            redirect_val_q <= 1'b1;
            state_q        <= ex_idle;
          end
        end
        default: state_q <= ex_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ex_idle && inst_val) begin
      d_q <= decode(inst_word, inst_pc);
    end
    if (state_q == ex_exec) begin
      next_pc_q <= next_pc_d;
    end
  end

  // ------------------------------------------------------------
  // Write back
  // ------------------------------------------------------------

  always_comb begin
    rf_wen   = 1'b0;
    rf_waddr = d_q.rd;
    rf_wdata = alu_result;
    if (state_q == ex_exec && !is_mem) begin
      rf_wen = writes_rd && (d_q.rd != '0);
    end else if (state_q == ex_mem && load_val && d_q.op == op_lw) begin
      rf_wen   = (d_q.rd != '0);
      rf_wdata = load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rf_wen) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  assign mem_val      = (state_q == ex_exec) && is_mem;
  assign mem_is_store = (d_q.op == op_sw);
  assign mem_addr     = alu_result;
  assign mem_wdata    = rs2_val;
  assign retire_val   = (state_q == ex_exec) && !is_mem;

  // Load data gets filled in by the data unit
  assign retire = '{pc:    d_q.pc,
                    waddr: d_q.rd,
                    wdata: writes_rd ? alu_result : 32'd0,
                    wen:   (writes_rd || d_q.op == op_lw) && (d_q.rd != '0)};

  assign redirect_val = redirect_val_q;
  assign next_pc      = next_pc_q;

  // Register file write agrees with the traced wen, and x0 is never the target
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    retire_val || load_val |-> rf_wen == retire.wen && !(rf_wen && rf_waddr == '0));

endmodule

// ==== core/data_mem_unit.sv ====
/*
 * Data access and retire. Sends loads and stores to the data port,
 * returns the response to execute and emits the one-cycle trace.
 */
module data_mem_unit
  import mem_pkg::*, core_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_val,
  input  logic        mem_is_store,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic        retire_val,
  input  trace_t      retire,
  output logic        dmem_req_val,
  output mem_req_t    dmem_req,
  input  logic        dmem_req_rdy,
  input  logic        dmem_resp_val,
  input  mem_resp_t   dmem_resp,
  output logic        dmem_resp_rdy,
  output logic        load_val,
  output logic [31:0] load_data,
  output logic        trace_val,
  output trace_t      trace
);

  typedef enum logic [1:0] {
    dm_idle,
    dm_req,
    dm_wait
  } dm_state_e;

  dm_state_e               state_q;
  logic [MEM_TAG_BITS-1:0] tag_q;
  mem_req_t                req_q;
  trace_t                  pend_q;
  trace_t                  trace_q;
  logic                    trace_val_q;

  // ------------------------------------------------------------
  // Access FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q     <= dm_idle;
      tag_q       <= '0;
      trace_val_q <= 1'b0;
    end else begin
      trace_val_q <= retire_val;
      case (state_q)
        dm_idle: begin
          if (mem_val) begin
            tag_q   <= tag_q + 1'b1;
            state_q <= dm_req;
          end
        end
        dm_req: if (dmem_req_rdy) state_q <= dm_wait;
        dm_wait: begin
          // Access done, instruction retires next cycle
          if (dmem_resp_val) begin
            trace_val_q <= 1'b1;
            state_q     <= dm_idle;
          end
        end
        default: state_q <= dm_idle;
      endcase
    end
  end

  // Request payload and pending trace
  always_ff @(posedge clk) begin
    if (state_q == dm_idle && mem_val) begin
      req_q  <= '{op:   mem_is_store ? mem_write : mem_read,
                  tag:  tag_q,
                  addr: mem_addr,
                  data: mem_wdata};
      pend_q <= retire;
    end
    if (retire_val) begin
      trace_q <= retire;
    end else if (load_val) begin
      trace_q <= pend_q;
      if (req_q.op == mem_read) trace_q.wdata <= dmem_resp.data;
    end
  end

  assign dmem_req_val  = (state_q == dm_req);
  assign dmem_req      = req_q;
  assign dmem_resp_rdy = (state_q == dm_wait);

  // Pulses for stores too so execute can retire them
  assign load_val  = dmem_resp_val && dmem_resp_rdy;
  assign load_data = dmem_resp.data;

  assign trace_val = trace_val_q;
  assign trace     = trace_q;

  a_dmem_req_stable: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && !dmem_req_rdy |=> dmem_req_val && $stable(dmem_req));

endmodule

// ==== rtl/blimp_core.sv ====
/*
 * Blimp RV32I core top. Joins fetch, execute and data access to the
 * instruction port, the data port and the retire trace.
 */
module blimp_core
  import mem_pkg::*, core_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Instruction port
  output logic      imem_req_val,
  input  logic      imem_req_rdy,
  output mem_req_t  imem_req,
  input  logic      imem_resp_val,
  output logic      imem_resp_rdy,
  input  mem_resp_t imem_resp,
  // Data port
  output logic      dmem_req_val,
  input  logic      dmem_req_rdy,
  output mem_req_t  dmem_req,
  input  logic      dmem_resp_val,
  output logic      dmem_resp_rdy,
  input  mem_resp_t dmem_resp,
  // Retire trace
  output logic      trace_val,
  output trace_t    trace
);

  // Fetch to execute
  logic        inst_val;
  logic [31:0] inst_word;
  logic [31:0] inst_pc;
  logic        redirect_val;
  logic [31:0] next_pc;

  // Execute to data access and back
  logic        mem_val;
  logic        mem_is_store;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        retire_val;
  trace_t      retire;
  logic        load_val;
  logic [31:0] load_data;

  fetch_unit u_fetch_unit (.*);

  execute_unit u_execute_unit (.*);

  data_mem_unit u_data_mem_unit (.*);

endmodule

// ==== bench/tb_blimp_core.sv ====
/*
 * Testbench for the blimp core. Shared two-port memory model with random
 * back-pressure, program builder, ISA reference model and trace checks.
 */
module tb_blimp_core
  import mem_pkg::*, core_pkg::*;
();

  logic      clk;
  logic      reset;
  logic      imem_req_val;
  logic      imem_req_rdy = 1'b0;
  mem_req_t  imem_req;
  logic      imem_resp_val = 1'b0;
  logic      imem_resp_rdy;
  mem_resp_t imem_resp = '0;
  logic      dmem_req_val;
  logic      dmem_req_rdy = 1'b0;
  mem_req_t  dmem_req;
  logic      dmem_resp_val = 1'b0;
  logic      dmem_resp_rdy;
  mem_resp_t dmem_resp = '0;
  logic      trace_val;
  trace_t    trace;

  // Word-indexed memories, DUT side and model side
  logic [31:0] mem [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] prog [$];
  trace_t      expect_q [$];

  logic [31:0] lfsr = 32'd74316;
  logic [31:0] rnd;
  logic        stress = 1'b0;
  logic        fetch_seen;
  int          errors = 0;
  int          checks = 0;
  int          retired = 0;
  logic        i_busy, d_busy;
  logic [1:0]  i_delay, d_delay;
  mem_resp_t   i_resp, d_resp;

  blimp_core u_blimp_core (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Random source and memory helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Unwritten words, mixed from every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9E37_79B9;
  endfunction

  function automatic logic [31:0] load_word(input logic [31:0] addr);
    return mem.exists(addr >> 2) ? mem[addr >> 2] : fill_word(addr);
  endfunction

  // ------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] lw(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
  endfunction

  function automatic logic [31:0] sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] bne(int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b001, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic build_alu();
    emit(addi(1, 0, 5));
    emit(addi(2, 0, -3));
    emit(lui(3, 'h12345));
    emit(rtype('h00, 0, 4, 1, 2));
    emit(rtype('h20, 0, 5, 1, 2));
    emit(rtype('h00, 7, 6, 3, 2));
    emit(rtype('h00, 6, 7, 1, 3));
    // Dropped write, then x0 as a source
    emit(addi(0, 1, 9));
    emit(rtype('h00, 0, 8, 0, 1));
  endtask

  task automatic build_mem();
    emit(lui(1, 1));
    emit(addi(2, 0, 'h5a5));
    emit(lui(3, 'hdeadb));
    emit(rtype('h00, 6, 2, 2, 3));
    emit(sw(2, 1, 8));
    emit(lw(4, 1, 8));
    emit(rtype('h00, 0, 5, 4, 0));
    emit(lw(0, 1, 8));
  endtask

  // Count x1 down from 5, add 3 to x2 per pass
  task automatic build_loop();
    emit(addi(1, 0, 5));
    emit(addi(2, 0, 0));
    emit(addi(2, 2, 3));
    emit(addi(1, 1, -1));
    emit(bne(1, 0, -8));
    emit(addi(3, 2, 1));
  endtask

  task automatic build_unsupported();
    emit(rtype('h00, 4, 1, 2, 3));
    emit(32'h0000_0073);
    emit(32'h0000_0283);
    emit(addi(1, 0, 1));
  endtask

  // ------------------------------------------------------------
  // ISA reference model that fills expect_q before the DUT runs
  // ------------------------------------------------------------

  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] pc, npc, w, a, b, res, addr, end_pc;
    logic        has_rd;
    trace_t      t;
    int          steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    expect_q.delete();
    ref_mem = mem;
    pc      = RESET_PC;
    end_pc  = RESET_PC + 32'(4 * prog.size());
    steps   = 0;
    while (pc != end_pc && steps < 500) begin
      w      = ref_mem.exists(pc >> 2) ? ref_mem[pc >> 2] : fill_word(pc);
      a      = regs[w[19:15]];
      b      = regs[w[24:20]];
      npc    = pc + 32'd4;
      has_rd = 1'b1;
      res    = '0;
      case (w[6:0])
        7'h13: begin
          if (w[14:12] == 3'd0) res = a + {{20{w[31]}}, w[31:20]};
          else has_rd = 1'b0;
        end
        7'h33: begin
          case ({w[31:25], w[14:12]})
            10'h000: res = a + b;
            10'h100: res = a - b;
            10'h007: res = a & b;
            10'h006: res = a | b;
            default: has_rd = 1'b0;
          endcase
        end
        7'h37: res = {w[31:12], 12'b0};
        7'h03: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          if (w[14:12] != 3'd2) has_rd = 1'b0;
          else res = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2] : fill_word(addr);
        end
        7'h23: begin
          has_rd = 1'b0;
          addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
          if (w[14:12] == 3'd2) ref_mem[addr >> 2] = b;
        end
        7'h63: begin
          has_rd = 1'b0;
          if (w[14:12] == 3'd1 && a != b)
            npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        default: has_rd = 1'b0;
      endcase
      t = '{pc: pc, waddr: '0, wdata: '0, wen: 1'b0};
      if (has_rd) begin
        t.waddr = w[11:7];
        t.wdata = res;
        t.wen   = (w[11:7] != 5'd0);
        if (t.wen) regs[w[11:7]] = res;
      end
      expect_q.push_back(t);
      pc = npc;
      steps++;
    end
  endtask

  // ------------------------------------------------------------
  // Memory model for both ports
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      imem_req_rdy  <= 1'b0;
      imem_resp_val <= 1'b0;
      dmem_req_rdy  <= 1'b0;
      dmem_resp_val <= 1'b0;
      i_busy = 1'b0;
      d_busy = 1'b0;
    end else begin
      // Instruction port
      if (imem_resp_val && imem_resp_rdy) imem_resp_val <= 1'b0;
      if (imem_req_val && imem_req_rdy) begin
        i_resp = '{op: mem_read, tag: imem_req.tag, data: load_word(imem_req.addr)};
        draw_bits(2, rnd);
        i_delay = stress ? rnd[1:0] : 2'd0;
        i_busy  = 1'b1;
      end
      if (i_busy && i_delay == 2'd0) begin
        imem_resp_val <= 1'b1;
        imem_resp     <= i_resp;
        i_busy = 1'b0;
      end else if (i_busy) begin
        i_delay--;
      end
      draw_bits(1, rnd);
      imem_req_rdy <= stress ? rnd[0] : 1'b1;
      // Data port where stores land at the request transfer
      if (dmem_resp_val && dmem_resp_rdy) dmem_resp_val <= 1'b0;
      if (dmem_req_val && dmem_req_rdy) begin
        d_resp = '{op: dmem_req.op, tag: dmem_req.tag, data: load_word(dmem_req.addr)};
        if (dmem_req.op == mem_write) mem[dmem_req.addr >> 2] = dmem_req.data;
        draw_bits(2, rnd);
        d_delay = stress ? rnd[1:0] : 2'd0;
        d_busy  = 1'b1;
      end
      if (d_busy && d_delay == 2'd0) begin
        dmem_resp_val <= 1'b1;
        dmem_resp     <= d_resp;
        d_busy = 1'b0;
      end else if (d_busy) begin
        d_delay--;
      end
      draw_bits(1, rnd);
      dmem_req_rdy <= stress ? rnd[0] : 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("Error: %s = %h, expected %h", name, got, want);
    errors++;
  endtask

  always @(posedge clk) begin
    if (reset) fetch_seen <= 1'b0;
    else if (imem_req_val && imem_req_rdy) fetch_seen <= 1'b1;
  end

  quiet_before_fetch: assert property (@(posedge clk) disable iff (reset)
    !fetch_seen |-> !trace_val && !dmem_req_val)
    else begin
      $display("Retire or data request seen before the first instruction fetch");
      errors++;
    end

  // Each retire against the next model record
  always @(posedge clk) begin
    trace_t exp;
    if (!reset && trace_val) begin
      retired++;
      assert (expect_q.size() != 0)
      else begin
        $display("Retire at pc %h beyond the end of the program", trace.pc);
        errors++;
      end
      if (expect_q.size() != 0) begin
        exp = expect_q.pop_front();
        checks++;
        assert (trace.pc == exp.pc) else report_value("trace.pc", trace.pc, exp.pc);
        assert (trace.waddr == exp.waddr)
          else report_value("trace.waddr", 32'(trace.waddr), 32'(exp.waddr));
        assert (trace.wdata == exp.wdata)
          else report_value("trace.wdata", trace.wdata, exp.wdata);
        assert (trace.wen == exp.wen)
          else report_value("trace.wen", 32'(trace.wen), 32'(exp.wen));
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    string name;
    int    n_expected;
    int    errs_before;
    int    cycles;
    int    failed_tests;
    logic  timed_out;
    reset        = 1'b1;
    failed_tests = 0;
    timed_out    = 1'b0;
    for (int t = 0; t < 6 && !timed_out; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      prog.delete();
      stress = 1'b0;
      case (t)
        0: begin
          name = "reset and first fetch";
          emit(lui(1, 1));
          emit(addi(1, 1, 3));
        end
        1: begin
          name = "alu and x0";
          build_alu();
        end
        2: begin
          name = "store then load";
          build_mem();
        end
        3: begin
          name = "bne loop";
          build_loop();
        end
        4: begin
          name   = "random back-pressure";
          stress = 1'b1;
          build_alu();
          build_mem();
          build_loop();
          build_unsupported();
        end
        default: begin
          name = "unsupported opcodes";
          build_unsupported();
        end
      endcase
      // Program goes in while the core is held in reset
      mem.delete();
      foreach (prog[i]) mem[(RESET_PC >> 2) + i] = prog[i];
      run_model();
      n_expected  = expect_q.size();
      retired     = 0;
      errs_before = errors;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      cycles = 0;
      while (retired < n_expected && cycles < 4000) begin
        @(negedge clk);
        cycles++;
      end
      if (retired < n_expected) begin
        $display("Timeout in test %0d: only %0d of %0d instructions retired",
                 t, retired, n_expected);
        timed_out = 1'b1;
        errors++;
      end
      // Stored words must be in memory as the model left them
      foreach (ref_mem[k]) begin
        assert (mem.exists(k) && mem[k] == ref_mem[k])
          else report_value("mem word", load_word(k << 2), ref_mem[k]);
      end
      if (errors != errs_before) failed_tests++;
      $display("test %0d %s: %0d of %0d retired, %s", t, name, retired, n_expected,
               (errors != errs_before) ? "failed" : "ok");
    end
    $display("%0d tests failed, %0d trace checks, %0d errors", failed_tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== blimp_core.f ====
common/mem_pkg.sv
common/core_pkg.sv
core/fetch_unit.sv
core/execute_unit.sv
core/data_mem_unit.sv
rtl/blimp_core.sv
bench/tb_blimp_core.sv

// ==== Makefile ====
# Verilator simulation of the blimp core testbench

VERILATOR ?= verilator
TOP       ?= tb_blimp_core
FILELIST  ?= blimp_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
